//--- rtl/dii_package.sv
package dii_package;

   typedef logic [15:0] dii_word_t;
   typedef logic [9:0]  dii_id_t;
   typedef logic [4:0]  pkt_len_t;                 // flit count of at most 16

   typedef struct packed {
      logic      valid;
      logic      last;
      dii_word_t data;
   } dii_flit;

   // packet type carried in flit 2
   typedef enum logic [15:0] {
      REQ_READ   = 16'h0000,
      REQ_WRITE  = 16'h0001,
      RESP_READ  = 16'h0002,
      RESP_WRITE = 16'h0003,
      RESP_ERROR = 16'h0004
   } pkt_type_e;

   typedef enum logic [3:0] {
      IDLE,
      SRC,
      TYPE,
      ADDR,
      WDATA,
      SKIP,
      R_DEST,
      R_SRC,
      R_TYPE,
      R_DATA
   } scm_state_e;

   localparam dii_word_t SCM_ADDR_MODTYPE = 16'd0;
   localparam dii_word_t SCM_ADDR_SYSID   = 16'd1;
   localparam dii_word_t SCM_ADDR_NUMMOD  = 16'd2;
   localparam dii_word_t SCM_ADDR_CTRL    = 16'd3;

   localparam dii_word_t SCM_MOD_TYPE     = 16'h0001;

endpackage

//--- rtl/flit_length_counter.sv
`timescale 1ns/1ns

module flit_length_counter (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  load,
   input  dii_package::pkt_len_t load_value,
   input  logic                  step,
   output dii_package::pkt_len_t count,
   output logic                  final_word
);

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (load) begin
         count <= load_value;
      end else if (step && count != 5'd0) begin
         count <= count - 5'd1;                    // one word consumed
      end
   end

   assign final_word = (count == 5'd1);

endmodule

//--- rtl/dii_packet_buffer.sv
`timescale 1ns/1ns

module dii_packet_buffer #(
   parameter int MAX_PKT_LEN = 16
) (
   input  logic                  clk,
   input  logic                  reset,
   input  dii_package::dii_flit  in_flit,
   output logic                  in_ready,
   output dii_package::dii_flit  out_flit,
   input  logic                  out_ready,
   output logic                  packet_ready,
   output dii_package::pkt_len_t packet_len
);
   import dii_package::*;

   localparam int AW = $clog2(MAX_PKT_LEN);

   dii_word_t              mem_data [MAX_PKT_LEN];
   logic [MAX_PKT_LEN-1:0] mem_last;
   logic [AW-1:0]          wr_ptr;
   logic [AW-1:0]          rd_ptr;
   logic [AW:0]            fill;
   pkt_len_t               wr_count;               // flits of the packet being written
   logic                   wr_en;
   logic                   rd_en;

   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
      return (ptr == AW'(MAX_PKT_LEN - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // a complete packet blocks further writes until it is drained
   assign in_ready       = (fill != (AW+1)'(MAX_PKT_LEN)) && !packet_ready;
   assign wr_en          = in_flit.valid && in_ready;
   assign out_flit.valid = (fill != '0);
   assign out_flit.last  = mem_last[rd_ptr];
   assign out_flit.data  = mem_data[rd_ptr];
   assign rd_en          = out_flit.valid && out_ready;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem_data[wr_ptr] <= in_flit.data;
         mem_last[wr_ptr] <= in_flit.last;
      end
      if (wr_en && in_flit.last) begin
         packet_len <= wr_count + 5'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         fill         <= '0;
         wr_count     <= '0;
         packet_ready <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr   <= next_ptr(wr_ptr);
            wr_count <= in_flit.last ? 5'd0 : wr_count + 5'd1;
         end
         if (rd_en) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         fill <= fill + (AW+1)'(wr_en) - (AW+1)'(rd_en);
         if (wr_en && in_flit.last) begin
            packet_ready <= 1'b1;
         end else if (rd_en && out_flit.last) begin
            packet_ready <= 1'b0;
         end
      end
   end

endmodule

//--- rtl/osd_him.sv
`timescale 1ns/1ns

module osd_him #(
   parameter int MAX_PKT_LEN = 16
) (
   input  logic                   clk,
   input  logic                   reset,
   input  dii_package::dii_word_t host_in_data,
   input  logic                   host_in_valid,
   output logic                   host_in_ready,
   output dii_package::dii_word_t host_out_data,
   output logic                   host_out_valid,
   input  logic                   host_out_ready,
   output dii_package::dii_flit   dii_out,
   input  logic                   dii_out_ready,
   input  dii_package::dii_flit   dii_in,
   output logic                   dii_in_ready
);
   import dii_package::*;

   pkt_len_t in_count;
   logic     in_final;
   logic     in_body;
   logic     in_xfer;
   pkt_len_t out_count;
   logic     out_body;
   logic     out_xfer;
   dii_flit  buf_flit;
   logic     buf_ready;
   logic     packet_ready;
   pkt_len_t packet_len;

   // host to ring path where a nonzero count means flit words follow
   assign in_body       = (in_count != 5'd0);
   assign host_in_ready = !in_body || !dii_out.valid || dii_out_ready;
   assign in_xfer       = host_in_valid && host_in_ready;

   flit_length_counter u_in_counter (
      .clk        (clk),
      .reset      (reset),
      .load       (in_xfer && !in_body),
      .load_value (host_in_data[4:0]),
      .step       (in_xfer && in_body),
      .count      (in_count),
      .final_word (in_final)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         dii_out.valid <= 1'b0;
      end else if (in_xfer && in_body) begin
         dii_out <= '{valid: 1'b1, last: in_final, data: host_in_data};
      end else if (dii_out_ready) begin
         dii_out.valid <= 1'b0;
      end
   end

   // ring to host path sends the length word once the whole packet is buffered
   dii_packet_buffer #(
      .MAX_PKT_LEN (MAX_PKT_LEN)
   ) u_buffer (
      .clk          (clk),
      .reset        (reset),
      .in_flit      (dii_in),
      .in_ready     (dii_in_ready),
      .out_flit     (buf_flit),
      .out_ready    (buf_ready),
      .packet_ready (packet_ready),
      .packet_len   (packet_len)
   );

   assign out_body       = (out_count != 5'd0);
   assign host_out_valid = out_body ? buf_flit.valid : packet_ready;
   assign host_out_data  = out_body ? buf_flit.data : {11'b0, packet_len};
   assign out_xfer       = host_out_valid && host_out_ready;
   assign buf_ready      = host_out_ready && out_body;

   flit_length_counter u_out_counter (
      .clk        (clk),
      .reset      (reset),
      .load       (out_xfer && !out_body),
      .load_value (packet_len),
      .step       (out_xfer && out_body),
      .count      (out_count),
      .final_word ()
   );

endmodule

//--- rtl/scm_request_fsm.sv
`timescale 1ns/1ns

module scm_request_fsm (
   input  logic                   clk,
   input  logic                   reset,
   input  dii_package::dii_id_t   id,
   input  dii_package::dii_flit   debug_in,
   output logic                   debug_in_ready,
   output dii_package::dii_flit   debug_out,
   input  logic                   debug_out_ready,
   output dii_package::dii_word_t reg_addr,
   output dii_package::dii_word_t reg_wdata,
   output logic                   reg_write,
   input  dii_package::dii_word_t reg_rdata,
   input  logic                   reg_valid
);
   import dii_package::*;

   scm_state_e state;
   dii_word_t  resp_dest;                          // source of the request
   dii_word_t  req_type;
   pkt_type_e  resp_type;
   dii_word_t  resp_data;
   logic       in_xfer;
   logic       out_free;
   logic       is_write;

   assign debug_in_ready = (state inside {IDLE, SRC, TYPE, ADDR, WDATA, SKIP});
   assign in_xfer        = debug_in.valid && debug_in_ready;
   assign out_free       = !debug_out.valid || debug_out_ready;
   assign is_write       = (req_type == REQ_WRITE);

   // the register access happens on the edge that sends the response header
   assign reg_write = (state == R_DEST) && out_free && is_write;

   always_ff @(posedge clk) begin
      if (reset) begin
         state           <= IDLE;
         debug_out.valid <= 1'b0;
      end else begin
         if (debug_out_ready) begin
            debug_out.valid <= 1'b0;
         end
         case (state)
            IDLE: begin
               if (in_xfer && !debug_in.last) begin
                  state <= SRC;
               end
            end
            SRC: begin
               if (in_xfer) begin
                  resp_dest <= debug_in.data;
                  state     <= debug_in.last ? IDLE : TYPE;
               end
            end
            TYPE: begin
               if (in_xfer) begin
                  req_type <= debug_in.data;
                  state    <= debug_in.last ? IDLE : ADDR;
               end
            end
            ADDR: begin
               if (in_xfer) begin
                  reg_addr <= debug_in.data;
                  if (is_write) begin
                     state <= debug_in.last ? IDLE : WDATA;   // write without data
                  end else begin
                     state <= debug_in.last ? R_DEST : SKIP;
                  end
               end
            end
            WDATA: begin
               if (in_xfer) begin
                  reg_wdata <= debug_in.data;
                  state     <= debug_in.last ? R_DEST : SKIP;
               end
            end
            SKIP: begin
               if (in_xfer && debug_in.last) begin
                  state <= R_DEST;
               end
            end
            R_DEST: begin
               if (out_free) begin
                  debug_out <= '{valid: 1'b1, last: 1'b0, data: resp_dest};
                  resp_data <= reg_rdata;
                  if (!reg_valid || !(is_write || req_type == REQ_READ)) begin
                     resp_type <= RESP_ERROR;
                  end else if (is_write) begin
                     resp_type <= RESP_WRITE;
                  end else begin
                     resp_type <= RESP_READ;
                  end
                  state <= R_SRC;
               end
            end
            R_SRC: begin
               if (out_free) begin
                  debug_out <= '{valid: 1'b1, last: 1'b0, data: {6'b0, id}};
                  state     <= R_TYPE;
               end
            end
            R_TYPE: begin
               if (out_free) begin
                  debug_out <= '{valid: 1'b1, last: resp_type != RESP_READ, data: resp_type};
                  state     <= (resp_type == RESP_READ) ? R_DATA : IDLE;
               end
            end
            R_DATA: begin
               if (out_free) begin
                  debug_out <= '{valid: 1'b1, last: 1'b1, data: resp_data};
                  state     <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

//--- rtl/osd_scm.sv
`timescale 1ns/1ns

module osd_scm #(
   parameter dii_package::dii_word_t SYSTEM_ID = 16'hdead,
   parameter dii_package::dii_word_t NUM_MOD   = 16'd3
) (
   input  logic                 clk,
   input  logic                 reset,
   input  dii_package::dii_id_t id,
   input  dii_package::dii_flit debug_in,
   output logic                 debug_in_ready,
   output dii_package::dii_flit debug_out,
   input  logic                 debug_out_ready,
   output logic                 sys_rst,
   output logic                 cpu_rst
);
   import dii_package::*;

   dii_word_t  reg_addr;
   dii_word_t  reg_wdata;
   dii_word_t  reg_rdata;
   logic       reg_write;
   logic       reg_valid;
   logic [1:0] ctrl;                               // cpu reset, system reset

   scm_request_fsm u_request_fsm (
      .clk             (clk),
      .reset           (reset),
      .id              (id),
      .debug_in        (debug_in),
      .debug_in_ready  (debug_in_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready),
      .reg_addr        (reg_addr),
      .reg_wdata       (reg_wdata),
      .reg_write       (reg_write),
      .reg_rdata       (reg_rdata),
      .reg_valid       (reg_valid)
   );

   always_comb begin
      reg_rdata = '0;
      reg_valid = !reg_write;                      // identification registers are read only
      case (reg_addr)
         SCM_ADDR_MODTYPE: reg_rdata = SCM_MOD_TYPE;
         SCM_ADDR_SYSID:   reg_rdata = SYSTEM_ID;
         SCM_ADDR_NUMMOD:  reg_rdata = NUM_MOD;
         SCM_ADDR_CTRL: begin
            reg_rdata = {14'b0, ctrl};
            reg_valid = 1'b1;
         end
         default: reg_valid = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ctrl <= 2'b00;
      end else if (reg_write && reg_addr == SCM_ADDR_CTRL) begin
         ctrl <= reg_wdata[1:0];
      end
   end

   assign sys_rst = ctrl[0];
   assign cpu_rst = ctrl[1];

endmodule

//--- rtl/debug_ring_router.sv
`timescale 1ns/1ns

module debug_ring_router (
   input  logic                 clk,
   input  logic                 reset,
   input  dii_package::dii_id_t id,
   input  dii_package::dii_flit ring_in,
   output logic                 ring_in_ready,
   output dii_package::dii_flit ring_out,
   input  logic                 ring_out_ready,
   input  dii_package::dii_flit local_in,
   output logic                 local_in_ready,
   output dii_package::dii_flit local_out,
   input  logic                 local_out_ready
);

   logic in_mid;                                   // ring input inside a packet
   logic route_local;
   logic out_busy;                                 // ring output inside a packet
   logic grant_local;                              // current or most recent owner
   logic ring_is_local;
   logic sel_local;
   logic rout_free;
   logic lout_free;
   logic ring_xfer;
   logic local_xfer;
   logic fwd_xfer;

   assign ring_is_local = in_mid ? route_local : (ring_in.data[9:0] == id);
   assign rout_free     = !ring_out.valid || ring_out_ready;
   assign lout_free     = !local_out.valid || local_out_ready;

   // at a packet boundary the injector wins unless it had the last grant
   assign sel_local = out_busy ? grant_local :
                      local_in.valid && (!(ring_in.valid && !ring_is_local) || !grant_local);

   assign ring_in_ready  = ring_is_local ? lout_free : (rout_free && !sel_local);
   assign local_in_ready = rout_free && sel_local;
   assign ring_xfer      = ring_in.valid && ring_in_ready;
   assign local_xfer     = local_in.valid && local_in_ready;
   assign fwd_xfer       = ring_xfer && !ring_is_local;

   always_ff @(posedge clk) begin
      if (reset) begin
         ring_out.valid  <= 1'b0;
         local_out.valid <= 1'b0;
         in_mid          <= 1'b0;
         route_local     <= 1'b0;
         out_busy        <= 1'b0;
         grant_local     <= 1'b0;
      end else begin
         if (ring_out_ready) begin
            ring_out.valid <= 1'b0;
         end
         if (local_out_ready) begin
            local_out.valid <= 1'b0;
         end
         if (ring_xfer) begin
            in_mid      <= !ring_in.last;
            route_local <= ring_is_local;
         end
         if (ring_xfer && ring_is_local) begin
            local_out <= ring_in;
         end
         if (fwd_xfer) begin
            ring_out <= ring_in;
            out_busy <= !ring_in.last;
         end else if (local_xfer) begin
            ring_out <= local_in;
            out_busy <= !local_in.last;
         end
         if (fwd_xfer || local_xfer) begin
            grant_local <= sel_local;
         end
      end
   end

endmodule

//--- rtl/debug_system.sv
`timescale 1ns/1ns

module debug_system #(
   parameter int                     MAX_PKT_LEN = 16,
   parameter dii_package::dii_word_t SYSTEM_ID   = 16'hdead,
   parameter dii_package::dii_word_t NUM_MOD     = 16'd3
) (
   input  logic                   clk,
   input  logic                   reset,
   input  dii_package::dii_word_t host_in_data,
   input  logic                   host_in_valid,
   output logic                   host_in_ready,
   output dii_package::dii_word_t host_out_data,
   output logic                   host_out_valid,
   input  logic                   host_out_ready,
   input  dii_package::dii_flit   ring_in,
   output logic                   ring_in_ready,
   output dii_package::dii_flit   ring_out,
   input  logic                   ring_out_ready,
   output logic                   sys_rst,
   output logic                   cpu_rst
);
   import dii_package::*;

   dii_flit him_out;
   logic    him_out_ready;
   dii_flit him_in;
   logic    him_in_ready;
   dii_flit scm_out;
   logic    scm_out_ready;
   dii_flit scm_in;
   logic    scm_in_ready;
   dii_flit ring_mid;                              // router_him to router_scm
   logic    ring_mid_ready;

   osd_him #(
      .MAX_PKT_LEN (MAX_PKT_LEN)
   ) u_him (
      .clk            (clk),
      .reset          (reset),
      .host_in_data   (host_in_data),
      .host_in_valid  (host_in_valid),
      .host_in_ready  (host_in_ready),
      .host_out_data  (host_out_data),
      .host_out_valid (host_out_valid),
      .host_out_ready (host_out_ready),
      .dii_out        (him_out),
      .dii_out_ready  (him_out_ready),
      .dii_in         (him_in),
      .dii_in_ready   (him_in_ready)
   );

   osd_scm #(
      .SYSTEM_ID (SYSTEM_ID),
      .NUM_MOD   (NUM_MOD)
   ) u_scm (
      .clk             (clk),
      .reset           (reset),
      .id              (10'd1),
      .debug_in        (scm_in),
      .debug_in_ready  (scm_in_ready),
      .debug_out       (scm_out),
      .debug_out_ready (scm_out_ready),
      .sys_rst         (sys_rst),
      .cpu_rst         (cpu_rst)
   );

   debug_ring_router router_him (
      .clk             (clk),
      .reset           (reset),
      .id              (10'd0),
      .ring_in         (ring_in),
      .ring_in_ready   (ring_in_ready),
      .ring_out        (ring_mid),
      .ring_out_ready  (ring_mid_ready),
      .local_in        (him_out),
      .local_in_ready  (him_out_ready),
      .local_out       (him_in),
      .local_out_ready (him_in_ready)
   );

   debug_ring_router router_scm (
      .clk             (clk),
      .reset           (reset),
      .id              (10'd1),
      .ring_in         (ring_mid),
      .ring_in_ready   (ring_mid_ready),
      .ring_out        (ring_out),
      .ring_out_ready  (ring_out_ready),
      .local_in        (scm_out),
      .local_in_ready  (scm_out_ready),
      .local_out       (scm_in),
      .local_out_ready (scm_in_ready)
   );

endmodule

//--- test/debug_system_checker.sv
`timescale 1ns/1ns

module debug_system_checker (
   input  logic                         clk,
   input  logic                         reset,
   input  dii_package::dii_word_t       host_out_data,
   input  logic                         host_out_valid,
   input  logic                         host_out_ready,
   input  dii_package::dii_flit         ring_out,
   input  logic                         ring_out_ready,
   input  logic                         sys_rst,
   input  logic                         cpu_rst,
   input  logic                         check_start,
   input  int                           test_num,
   input  logic                         exp_on_ring,
   input  int                           exp_count,
   input  dii_package::dii_word_t [4:0] exp_flits,
   input  logic [1:0]                   exp_pins,          // cpu_rst, sys_rst
   output logic                         test_done,
   output int                           pass_count,
   output int                           fail_count,
   output int                           error_count
);
   import dii_package::*;

   logic      armed;
   logic      ring_first;
   logic      ring_watch;                                   // ring_out packet leaves the ring
   dii_word_t host_words [$];                               // length word first
   dii_word_t ring_words [$];

   task automatic finish_packet(input logic on_ring);
      int        errs;
      int        got_count;
      dii_word_t got;
      errs = 0;
      got_count = on_ring ? ring_words.size() : host_words.size() - 1;
      if (!armed || on_ring != exp_on_ring) begin
         $display("Error at %0t ns: unexpected packet of %0d flits on %s", $time, got_count,
                  on_ring ? "ring_out" : "host_out");
         error_count++;
      end else begin
         if (got_count != exp_count) begin
            $display("Error at %0t ns: test %0d packet has %0d flits, expected %0d",
                     $time, test_num, got_count, exp_count);
            errs++;
         end
         for (int i = 0; i < got_count && i < exp_count; i++) begin
            got = on_ring ? ring_words[i] : host_words[i + 1];
            if (got != exp_flits[i]) begin
               $display("Error at %0t ns: test %0d flit %0d is %h, expected %h",
                        $time, test_num, i, got, exp_flits[i]);
               errs++;
            end
         end
         if ({cpu_rst, sys_rst} != exp_pins) begin
            $display("Error at %0t ns: test %0d reset pins are %b, expected %b",
                     $time, test_num, {cpu_rst, sys_rst}, exp_pins);
            errs++;
         end
         if (errs == 0) begin
            $display("test %0d passed", test_num);
            pass_count++;
         end else begin
            $display("test %0d failed with %0d mismatches", test_num, errs);
            fail_count++;
         end
         error_count += errs;
         armed = 1'b0;
         test_done <= 1'b1;
      end
   endtask

   always @(posedge clk) begin
      logic watch_now;
      if (reset) begin
         armed       = 1'b0;
         ring_first  = 1'b1;
         ring_watch  = 1'b0;
         pass_count  = 0;
         fail_count  = 0;
         error_count = 0;
         host_words.delete();
         ring_words.delete();
         test_done  <= 1'b0;
      end else begin
         if (check_start) begin
            armed = 1'b1;
            test_done <= 1'b0;
         end
         if (host_out_valid && host_out_ready) begin
            host_words.push_back(host_out_data);
            if (host_words.size() == int'(host_words[0]) + 1) begin
               finish_packet(1'b0);
               host_words.delete();
            end
         end
         if (ring_out.valid && ring_out_ready) begin
            watch_now  = ring_first ? (ring_out.data[9:0] > 10'd1) : ring_watch;
            ring_first = ring_out.last;
            ring_watch = watch_now;
            if (watch_now) begin
               ring_words.push_back(ring_out.data);
               if (ring_out.last) begin
                  finish_packet(1'b1);
                  ring_words.delete();
               end
            end
         end
      end
   end

endmodule

//--- test/debug_system_tb.sv
`timescale 1ns/1ns

module debug_system_tb;
   import dii_package::*;

   localparam int        MAX_PKT_LEN = 16;
   localparam dii_word_t SYSTEM_ID   = 16'hdead;
   localparam dii_word_t NUM_MOD     = 16'd3;
   localparam int        NUM_TESTS   = 14;
   localparam int        TIMEOUT     = 1000;                 // cycles per wait

   typedef struct packed {
      logic      from_ring;                                 // injected on ring_in
      dii_id_t   dest;
      dii_word_t req_type;
      dii_word_t addr;
      dii_word_t wdata;
      dii_word_t resp_type;
      dii_word_t resp_data;
      logic      sys_rst;
      logic      cpu_rst;
   } test_entry_t;

   logic            clk;
   logic            reset;
   dii_word_t       host_in_data;
   logic            host_in_valid;
   logic            host_in_ready;
   dii_word_t       host_out_data;
   logic            host_out_valid;
   logic            host_out_ready = 1'b1;
   dii_flit         ring_in = '0;
   logic            ring_in_ready;
   dii_flit         ring_out;
   logic            ring_out_ready = 1'b1;
   logic            sys_rst;
   logic            cpu_rst;
   logic            check_start;
   int              test_num;
   logic            exp_on_ring;
   int              exp_count;
   dii_word_t [4:0] exp_flits;
   logic [1:0]      exp_pins;
   logic            test_done;
   int              pass_count;
   int              fail_count;
   int              error_count;
   test_entry_t     tests [NUM_TESTS];
   dii_flit         ring_q [$];                             // flits waiting for ring_in
   logic            ring_first;
   logic            loop_pkt;
   logic            random_mode;
   logic            timed_out;
   logic [31:0]     lcg_state = 32'd39709;

   debug_system #(
      .MAX_PKT_LEN (MAX_PKT_LEN),
      .SYSTEM_ID   (SYSTEM_ID),
      .NUM_MOD     (NUM_MOD)
   ) i_debug_system (
      .clk            (clk),
      .reset          (reset),
      .host_in_data   (host_in_data),
      .host_in_valid  (host_in_valid),
      .host_in_ready  (host_in_ready),
      .host_out_data  (host_out_data),
      .host_out_valid (host_out_valid),
      .host_out_ready (host_out_ready),
      .ring_in        (ring_in),
      .ring_in_ready  (ring_in_ready),
      .ring_out       (ring_out),
      .ring_out_ready (ring_out_ready),
      .sys_rst        (sys_rst),
      .cpu_rst        (cpu_rst)
   );

   debug_system_checker i_debug_system_checker (
      .clk            (clk),
      .reset          (reset),
      .host_out_data  (host_out_data),
      .host_out_valid (host_out_valid),
      .host_out_ready (host_out_ready),
      .ring_out       (ring_out),
      .ring_out_ready (ring_out_ready),
      .sys_rst        (sys_rst),
      .cpu_rst        (cpu_rst),
      .check_start    (check_start),
      .test_num       (test_num),
      .exp_on_ring    (exp_on_ring),
      .exp_count      (exp_count),
      .exp_flits      (exp_flits),
      .exp_pins       (exp_pins),
      .test_done      (test_done),
      .pass_count     (pass_count),
      .fail_count     (fail_count),
      .error_count    (error_count)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] next_random(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   always @(posedge clk) begin
      lcg_state      <= next_random(lcg_state);
      host_out_ready <= !random_mode || lcg_state[31];
      ring_out_ready <= !random_mode || lcg_state[29];
   end

   // outer ring segment that loops ids 0 and 1 back to ring_in
   always @(posedge clk) begin
      logic loop_now;
      if (reset) begin
         ring_first <= 1'b1;
         loop_pkt   <= 1'b0;
         ring_in    <= '0;
      end else begin
         loop_now = ring_first ? (ring_out.data[9:0] < 10'd2) : loop_pkt;
         if (ring_out.valid && ring_out_ready) begin
            ring_first <= ring_out.last;
            loop_pkt   <= loop_now;
            if (loop_now) begin
               ring_q.push_back(ring_out);
            end
         end
         if (!ring_in.valid || ring_in_ready) begin
            if (ring_q.size() != 0) begin
               ring_in <= ring_q.pop_front();
            end else begin
               ring_in <= '0;
            end
         end
      end
   end

   task automatic load_table();
      tests[0]  = '{1'b0, 10'd1, REQ_READ, SCM_ADDR_MODTYPE, 16'h0, RESP_READ, SCM_MOD_TYPE,
                    1'b0, 1'b0};
      tests[1]  = '{1'b0, 10'd1, REQ_READ, SCM_ADDR_SYSID, 16'h0, RESP_READ, SYSTEM_ID,
                    1'b0, 1'b0};
      tests[2]  = '{1'b0, 10'd1, REQ_READ, SCM_ADDR_NUMMOD, 16'h0, RESP_READ, NUM_MOD,
                    1'b0, 1'b0};
      tests[3]  = '{1'b0, 10'd1, REQ_WRITE, SCM_ADDR_CTRL, 16'h0001, RESP_WRITE, 16'h0,
                    1'b1, 1'b0};
      tests[4]  = '{1'b0, 10'd1, REQ_READ, SCM_ADDR_CTRL, 16'h0, RESP_READ, 16'h0001,
                    1'b1, 1'b0};
      tests[5]  = '{1'b0, 10'd1, REQ_WRITE, SCM_ADDR_CTRL, 16'h0002, RESP_WRITE, 16'h0,
                    1'b0, 1'b1};
      tests[6]  = '{1'b0, 10'd1, REQ_READ, SCM_ADDR_CTRL, 16'h0, RESP_READ, 16'h0002,
                    1'b0, 1'b1};
      tests[7]  = '{1'b0, 10'd1, REQ_READ, 16'd5, 16'h0, RESP_ERROR, 16'h0, 1'b0, 1'b1};
      tests[8]  = '{1'b0, 10'd1, REQ_WRITE, SCM_ADDR_SYSID, 16'h1234, RESP_ERROR, 16'h0,
                    1'b0, 1'b1};
      tests[9]  = '{1'b0, 10'd2, REQ_WRITE, 16'h0040, 16'hbeef, 16'h0, 16'h0, 1'b0, 1'b1};
      tests[10] = '{1'b1, 10'd0, REQ_WRITE, 16'h0041, 16'h5a5a, 16'h0, 16'h0, 1'b0, 1'b1};
      tests[11] = '{1'b0, 10'd1, REQ_WRITE, SCM_ADDR_CTRL, 16'h0003, RESP_WRITE, 16'h0,
                    1'b1, 1'b1};
      tests[12] = '{1'b0, 10'd1, REQ_WRITE, SCM_ADDR_CTRL, 16'hfffc, RESP_WRITE, 16'h0,
                    1'b0, 1'b0};
      tests[13] = '{1'b0, 10'd1, REQ_READ, SCM_ADDR_CTRL, 16'h0, RESP_READ, 16'h0000,
                    1'b0, 1'b0};
   endtask

   task automatic send_word(input dii_word_t word, input int num);
      int waited;
      host_in_data  <= word;
      host_in_valid <= 1'b1;
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
      end while (!host_in_ready && waited < TIMEOUT);
      if (!host_in_ready) begin
         $display("Timeout: the DUT did not accept a host word during test %0d", num);
         timed_out = 1'b1;
      end
   endtask

   task automatic run_test(input int num, input test_entry_t t);
      dii_word_t req [5];
      dii_word_t src;
      int        req_len;
      int        waited;
      src     = t.from_ring ? 16'd2 : 16'd0;
      req_len = (t.req_type == REQ_WRITE) ? 5 : 4;
      req[0]  = {6'b0, t.dest};
      req[1]  = src;
      req[2]  = t.req_type;
      req[3]  = t.addr;
      req[4]  = t.wdata;
      @(posedge clk);
      test_num <= num;
      exp_pins <= {t.cpu_rst, t.sys_rst};
      if (t.dest == 10'd1) begin
         exp_on_ring <= 1'b0;                               // response returns to the source
         exp_count   <= (t.resp_type == RESP_READ) ? 4 : 3;
         exp_flits   <= {16'h0, t.resp_data, t.resp_type, 16'd1, src};
      end else begin
         exp_on_ring <= (t.dest == 10'd2);
         exp_count   <= req_len;
         exp_flits   <= {req[4], req[3], req[2], req[1], req[0]};
      end
      check_start <= 1'b1;
      @(posedge clk);
      check_start <= 1'b0;
      if (t.from_ring) begin
         for (int k = 0; k < req_len; k++) begin
            ring_q.push_back('{1'b1, k == req_len - 1, req[k]});
         end
      end else begin
         send_word(dii_word_t'(req_len), num);
         for (int k = 0; k < req_len && !timed_out; k++) begin
            send_word(req[k], num);
         end
         host_in_valid <= 1'b0;
      end
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
      end while (!test_done && !timed_out && waited < TIMEOUT);
      if (!test_done && !timed_out) begin
         $display("Timeout: no result arrived for test %0d within %0d cycles", num, TIMEOUT);
         timed_out = 1'b1;
      end
   endtask

   initial begin
      reset         = 1'b1;
      host_in_data  = '0;
      host_in_valid = 1'b0;
      check_start   = 1'b0;
      test_num      = 0;
      exp_on_ring   = 1'b0;
      exp_count     = 0;
      exp_flits     = '0;
      exp_pins      = 2'b00;
      random_mode   = 1'b0;
      timed_out     = 1'b0;
      load_table();
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      // second round repeats the table with random back-pressure
      for (int round = 0; round < 2 && !timed_out; round++) begin
         random_mode <= (round == 1);
         for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
            run_test(round * NUM_TESTS + i, tests[i]);
         end
      end
      $display("%0d tests passed, %0d tests failed, %0d errors",
               pass_count, fail_count, error_count);
      if (timed_out || fail_count != 0 || error_count != 0) begin
         $display("Test failed");
      end else begin
         $display("Test completed successfully");
      end
      $finish;
   end

endmodule

//--- compile.f
rtl/dii_package.sv
rtl/flit_length_counter.sv
rtl/dii_packet_buffer.sv
rtl/osd_him.sv
rtl/scm_request_fsm.sv
rtl/osd_scm.sv
rtl/debug_ring_router.sv
rtl/debug_system.sv
test/debug_system_checker.sv
test/debug_system_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns --top-module debug_system_tb \
   -f compile.f -o debug_system_sim || exit 1
sim_output=$(./obj_dir/debug_system_sim)
echo "$sim_output"
echo "$sim_output" | grep -q "Test completed successfully" && exit 0 || exit 1
